// File: Makefile
# Verilator flow for the AXI4-Lite ALU peripheral.

VERILATOR ?= verilator
TOP       ?= tb_axil_alu
RTL_TOP   ?= axil_alu_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu_execute.sv
`timescale 1ns/1ps

module alu_execute
   import alu_pkg::*;
(
   input  logic        clk_i,      // System clock.
   input  logic        arst_n_i,   // Async reset, active low.
   input  alu_cmd_t    cmd_i,      // Start command.
   output logic        busy_o,     // Operation running.
   output logic [31:0] result_o,   // Last result.
   output logic        done_o      // Result is current.
);

   typedef enum logic {
      EX_IDLE,                     // Waiting for start.
      EX_BUSY                      // Computing.
   } ex_state_e;

   ex_state_e   state_q;
   alu_op_e     op_q;              // Captured opcode.
   logic [31:0] a_q;               // Captured operand A.
   logic [31:0] b_q;               // Captured operand B.
   logic [31:0] alu_res;           // Combinational result.
   logic [31:0] result_q;
   logic        done_q;

   always_comb begin
      case (op_q)
         OP_ADD:  alu_res = a_q + b_q;
         OP_SUB:  alu_res = a_q - b_q;
         OP_AND:  alu_res = a_q & b_q;
         OP_OR:   alu_res = a_q | b_q;
         OP_XOR:  alu_res = a_q ^ b_q;
         OP_SHL:  alu_res = a_q << b_q[4:0];     // Shift amount 0..31.
         OP_SHR:  alu_res = a_q >> b_q[4:0];
         OP_MUL:  alu_res = a_q * b_q;           // Keeps low word.
         default: alu_res = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= EX_IDLE;
         result_q <= '0;
         done_q   <= 1'b0;
      end else begin
         case (state_q)
            EX_IDLE: begin
               if (cmd_i.start) begin
                  state_q <= EX_BUSY;
                  done_q  <= 1'b0;               // Clears on start.
               end
            end
            EX_BUSY: begin
               state_q  <= EX_IDLE;              // Single busy cycle.
               result_q <= alu_res;
               done_q   <= 1'b1;
            end
            default: state_q <= EX_IDLE;
         endcase
      end
   end

   // Operands are sampled once per start.
   always_ff @(posedge clk_i) begin
      if (state_q == EX_IDLE && cmd_i.start) begin
         op_q <= cmd_i.opcode;
         a_q  <= cmd_i.opa;
         b_q  <= cmd_i.opb;
      end
   end

   assign busy_o   = (state_q == EX_BUSY);
   assign result_o = result_q;
   assign done_o   = done_q;

endmodule

// File: alu_pkg.sv
package alu_pkg;

   // ALU opcodes, as written to CTRL[2:0].
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,   // A + B.
      OP_SUB = 3'd1,   // A - B.
      OP_AND = 3'd2,   // Bitwise and.
      OP_OR  = 3'd3,   // Bitwise or.
      OP_XOR = 3'd4,   // Bitwise xor.
      OP_SHL = 3'd5,   // A << B[4:0].
      OP_SHR = 3'd6,   // Logical A >> B[4:0].
      OP_MUL = 3'd7    // Low 32 bits of A * B.
   } alu_op_e;

   // Decoded register select.
   typedef enum logic [2:0] {
      REG_OPA    = 3'd0,  // Operand A.
      REG_OPB    = 3'd1,  // Operand B.
      REG_CTRL   = 3'd2,  // Opcode and start.
      REG_RESULT = 3'd3,  // Last result.
      REG_STATUS = 3'd4,  // Done flag in bit 0.
      REG_NONE   = 3'd5   // Hole in the map.
   } alu_reg_e;

   // Byte offsets of the register map.
   localparam logic [4:0] OFF_OPA    = 5'h00;
   localparam logic [4:0] OFF_OPB    = 5'h04;
   localparam logic [4:0] OFF_CTRL   = 5'h08;
   localparam logic [4:0] OFF_RESULT = 5'h0c;
   localparam logic [4:0] OFF_STATUS = 5'h10;

   // Start command from decoder to execute.
   typedef struct packed {
      logic        start;   // One-cycle pulse.
      alu_op_e     opcode;  // Operation to run.
      logic [31:0] opa;     // Operand A register.
      logic [31:0] opb;     // Operand B register.
   } alu_cmd_t;

endpackage

// File: alu_read_result.sv
`timescale 1ns/1ps

module alu_read_result
   import axil_pkg::*;
   import alu_pkg::*;
(
   input  logic                   clk_i,      // System clock.
   input  logic                   arst_n_i,   // Async reset, active low.
   input  logic                   rd_en_i,    // Read accepted.
   input  alu_reg_e               rd_sel_i,   // Register to return.
   input  logic [AXIL_DATA_W-1:0] opa_i,
   input  logic [AXIL_DATA_W-1:0] opb_i,
   input  logic [AXIL_DATA_W-1:0] result_i,
   input  alu_op_e                opcode_i,
   input  logic                   done_i,
   output logic                   rvalid_o,   // One pulse per read.
   output logic [AXIL_DATA_W-1:0] rdata_o     // Registered read word.
);

   logic [AXIL_DATA_W-1:0] rd_mux;            // Word for the selected register.
   logic                   rvalid_q;
   logic [AXIL_DATA_W-1:0] rdata_q;

   always_comb begin
      case (rd_sel_i)
         REG_OPA:    rd_mux = opa_i;
         REG_OPB:    rd_mux = opb_i;
         REG_CTRL:   rd_mux = {{(AXIL_DATA_W-3){1'b0}}, opcode_i};   // Zero-extended.
         REG_RESULT: rd_mux = result_i;
         REG_STATUS: rd_mux = {{(AXIL_DATA_W-1){1'b0}}, done_i};     // Done in bit 0.
         default:    rd_mux = '0;                                     // Unmapped.
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en_i;                   // Exactly one cycle later.
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rdata_q <= rd_mux;
      end
   end

   assign rvalid_o = rvalid_q;
   assign rdata_o  = rdata_q;

endmodule

// File: alu_reg_decode.sv
`timescale 1ns/1ps

module alu_reg_decode
   import axil_pkg::*;
   import alu_pkg::*;
(
   input  logic     clk_i,       // System clock.
   input  logic     arst_n_i,    // Async reset, active low.
   input  iob_req_t iob_req_i,   // Request from the bridge.
   input  logic     busy_i,      // Execute is running.
   output logic     ready_o,     // Request accept.
   output alu_cmd_t cmd_o,       // Start command and operands.
   output alu_reg_e rd_sel_o,    // Register being read.
   output logic     rd_en_o,     // Read accepted.
   output alu_op_e  opcode_o     // Current opcode.
);

   alu_reg_e                sel;       // Decoded target.
   logic                    accept;    // Handshake done.
   logic                    is_wr;     // Any strobe set.
   logic [AXIL_DATA_W-1:0]  opa_q;
   logic [AXIL_DATA_W-1:0]  opb_q;
   alu_op_e                 opcode_q;
   logic                    start_q;   // Start pulse.

   function automatic logic [AXIL_DATA_W-1:0] merge_bytes(
      input logic [AXIL_DATA_W-1:0] old_v,
      input logic [AXIL_DATA_W-1:0] new_v,
      input logic [AXIL_STRB_W-1:0] strb
   );
      logic [AXIL_DATA_W-1:0] res;
      res = old_v;
      for (int i = 0; i < AXIL_STRB_W; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_v[8*i +: 8];           // Replace enabled byte.
         end
      end
      return res;
   endfunction

   always_comb begin
      case ({iob_req_i.addr[4:2], 2'b00})              // Word offset only.
         OFF_OPA:    sel = REG_OPA;
         OFF_OPB:    sel = REG_OPB;
         OFF_CTRL:   sel = REG_CTRL;
         OFF_RESULT: sel = REG_RESULT;
         OFF_STATUS: sel = REG_STATUS;
         default:    sel = REG_NONE;
      endcase
   end

   assign ready_o = ~(busy_i | start_q);                // Hold off until the op runs.
   assign accept  = iob_req_i.valid & ready_o;
   assign is_wr   = |iob_req_i.wstrb;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         opa_q    <= '0;
         opb_q    <= '0;
         opcode_q <= OP_ADD;
         start_q  <= 1'b0;
      end else begin
         start_q <= accept & is_wr & (sel == REG_CTRL);  // Start one cycle later.
         if (accept && is_wr) begin
            case (sel)
               REG_OPA:  opa_q <= merge_bytes(opa_q, iob_req_i.wdata, iob_req_i.wstrb);
               REG_OPB:  opb_q <= merge_bytes(opb_q, iob_req_i.wdata, iob_req_i.wstrb);
               REG_CTRL: begin
                  if (iob_req_i.wstrb[0]) begin
                     opcode_q <= alu_op_e'(iob_req_i.wdata[2:0]);
                  end
               end
               default: ;                                // Read-only or unmapped.
            endcase
         end
      end
   end

   assign cmd_o    = '{start: start_q, opcode: opcode_q, opa: opa_q, opb: opb_q};
   assign rd_sel_o = sel;
   assign rd_en_o  = accept & ~is_wr;
   assign opcode_o = opcode_q;

endmodule

// File: axil2iob.sv
`timescale 1ns/1ps

module axil2iob
   import axil_pkg::*;
#(
   parameter int AXIL_ID_W = 1                     // AXI ID width.
) (
   input  logic                   clk_i,           // System clock.
   input  logic                   arst_n_i,        // Async reset, active low.
   input  axil_aw_t               axil_aw_i,       // Write address beat.
   input  logic [AXIL_ID_W-1:0]   axil_awid_i,     // Write ID.
   input  logic                   axil_awvalid_i,
   output logic                   axil_awready_o,
   input  axil_w_t                axil_w_i,        // Write data beat.
   input  logic                   axil_wvalid_i,
   output logic                   axil_wready_o,
   output logic [AXIL_ID_W-1:0]   axil_bid_o,      // Echoed write ID.
   output logic [1:0]             axil_bresp_o,
   output logic                   axil_bvalid_o,
   input  logic                   axil_bready_i,
   input  logic [AXIL_ADDR_W-1:0] axil_araddr_i,   // Read address.
   input  logic [AXIL_ID_W-1:0]   axil_arid_i,     // Read ID.
   input  logic                   axil_arvalid_i,
   output logic                   axil_arready_o,
   output axil_r_t                axil_r_o,        // Read data beat.
   output logic [AXIL_ID_W-1:0]   axil_rid_o,      // Echoed read ID.
   output logic                   axil_rvalid_o,
   input  logic                   axil_rready_i,
   output iob_req_t               iob_req_o,       // IOb request.
   input  iob_rsp_t               iob_rsp_i        // IOb response.
);

   logic                   wr_present;     // Any write channel active.
   logic                   wr_req;         // Write can be offered.
   logic                   rd_req;         // Read can be offered.
   logic                   wr_go;          // Write taken this cycle.
   logic                   rd_go;          // Read taken this cycle.
   logic                   bvalid_q;       // Held B response.
   logic [AXIL_ID_W-1:0]   bid_q;
   logic                   rvalid_q;       // Held R response.
   logic [AXIL_ID_W-1:0]   rid_q;
   logic [AXIL_DATA_W-1:0] rdata_q;
   logic                   rd_inflight_q;  // Waiting on IOb rvalid.

   // Writes win, reads wait behind any pending response.
   assign wr_present = axil_awvalid_i | axil_wvalid_i;
   assign wr_req     = axil_awvalid_i & axil_wvalid_i & ~bvalid_q;
   assign rd_req     = axil_arvalid_i & ~wr_present & ~rvalid_q & ~rd_inflight_q;
   assign wr_go      = wr_req & iob_rsp_i.ready;
   assign rd_go      = rd_req & iob_rsp_i.ready;

   always_comb begin
      iob_req_o.valid = wr_req | rd_req;                     // Independent of ready.
      iob_req_o.addr  = wr_req ? axil_aw_i.addr : axil_araddr_i;
      iob_req_o.wdata = axil_w_i.data;
      iob_req_o.wstrb = wr_req ? axil_w_i.strb : '0;        // Zero strobe is a read.
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bvalid_q      <= 1'b0;
         rvalid_q      <= 1'b0;
         rd_inflight_q <= 1'b0;
      end else begin
         if (wr_go) begin
            bvalid_q <= 1'b1;                                // B rises next cycle.
         end else if (axil_bready_i) begin
            bvalid_q <= 1'b0;
         end
         if (rd_go) begin
            rd_inflight_q <= 1'b1;
         end else if (iob_rsp_i.rvalid) begin
            rd_inflight_q <= 1'b0;
         end
         if (iob_rsp_i.rvalid && rd_inflight_q) begin
            rvalid_q <= 1'b1;                                // Held until rready.
         end else if (axil_rready_i) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_go) begin
         bid_q <= axil_awid_i;
      end
      if (rd_go) begin
         rid_q <= axil_arid_i;
      end
      if (iob_rsp_i.rvalid && rd_inflight_q) begin
         rdata_q <= iob_rsp_i.rdata;                         // Capture the read word.
      end
   end

   assign axil_awready_o = wr_go;                           // AW and W pulse together.
   assign axil_wready_o  = wr_go;
   assign axil_bid_o     = bid_q;
   assign axil_bresp_o   = AXIL_RESP_OKAY;
   assign axil_bvalid_o  = bvalid_q;
   assign axil_arready_o = rd_go;
   assign axil_r_o       = '{data: rdata_q, resp: AXIL_RESP_OKAY};
   assign axil_rid_o     = rid_q;
   assign axil_rvalid_o  = rvalid_q;

endmodule

// File: axil_alu_top.sv
`timescale 1ns/1ps

module axil_alu_top
   import axil_pkg::*;
   import alu_pkg::*;
#(
   parameter int AXIL_ID_W = 1                     // AXI ID width.
) (
   input  logic                   clk_i,           // System clock.
   input  logic                   arst_n_i,        // Async reset, active low.
   input  axil_aw_t               axil_aw_i,
   input  logic [AXIL_ID_W-1:0]   axil_awid_i,
   input  logic                   axil_awvalid_i,
   output logic                   axil_awready_o,
   input  axil_w_t                axil_w_i,
   input  logic                   axil_wvalid_i,
   output logic                   axil_wready_o,
   output logic [AXIL_ID_W-1:0]   axil_bid_o,
   output logic [1:0]             axil_bresp_o,
   output logic                   axil_bvalid_o,
   input  logic                   axil_bready_i,
   input  logic [AXIL_ADDR_W-1:0] axil_araddr_i,
   input  logic [AXIL_ID_W-1:0]   axil_arid_i,
   input  logic                   axil_arvalid_i,
   output logic                   axil_arready_o,
   output axil_r_t                axil_r_o,
   output logic [AXIL_ID_W-1:0]   axil_rid_o,
   output logic                   axil_rvalid_o,
   input  logic                   axil_rready_i
);

   iob_req_t               iob_req;      // Bridge request.
   iob_rsp_t               iob_rsp;      // Merged response.
   alu_cmd_t               cmd;          // Start and operands.
   alu_reg_e               rd_sel;
   alu_op_e                opcode;
   logic                   dec_ready;
   logic                   rd_en;
   logic                   busy;
   logic                   done;
   logic [31:0]            result;
   logic                   res_rvalid;
   logic [AXIL_DATA_W-1:0] res_rdata;

   // Ready from the decoder, read data from the result block.
   assign iob_rsp = '{ready: dec_ready, rvalid: res_rvalid, rdata: res_rdata};

   axil2iob #(
      .AXIL_ID_W(AXIL_ID_W)
   ) u_bridge (
      .clk_i, .arst_n_i,
      .axil_aw_i, .axil_awid_i, .axil_awvalid_i, .axil_awready_o,
      .axil_w_i, .axil_wvalid_i, .axil_wready_o,
      .axil_bid_o, .axil_bresp_o, .axil_bvalid_o, .axil_bready_i,
      .axil_araddr_i, .axil_arid_i, .axil_arvalid_i, .axil_arready_o,
      .axil_r_o, .axil_rid_o, .axil_rvalid_o, .axil_rready_i,
      .iob_req_o(iob_req),
      .iob_rsp_i(iob_rsp)
   );

   alu_reg_decode u_decode (
      .clk_i, .arst_n_i,
      .iob_req_i(iob_req),
      .busy_i(busy),
      .ready_o(dec_ready),
      .cmd_o(cmd),
      .rd_sel_o(rd_sel),
      .rd_en_o(rd_en),
      .opcode_o(opcode)
   );

   alu_execute u_execute (
      .clk_i, .arst_n_i,
      .cmd_i(cmd),
      .busy_o(busy),
      .result_o(result),
      .done_o(done)
   );

   alu_read_result u_result (
      .clk_i, .arst_n_i,
      .rd_en_i(rd_en),
      .rd_sel_i(rd_sel),
      .opa_i(cmd.opa),
      .opb_i(cmd.opb),
      .result_i(result),
      .opcode_i(opcode),
      .done_i(done),
      .rvalid_o(res_rvalid),
      .rdata_o(res_rdata)
   );

endmodule

// File: axil_pkg.sv
package axil_pkg;

   localparam int AXIL_ADDR_W = 32;             // Byte address width.
   localparam int AXIL_DATA_W = 32;             // Bus word width.
   localparam int AXIL_STRB_W = AXIL_DATA_W/8;  // One strobe per byte.

   localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;  // Only response ever sent.

   // Write address beat. The ID travels on its own port.
   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;    // Byte address.
   } axil_aw_t;

   // Write data beat.
   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;    // Write word.
      logic [AXIL_STRB_W-1:0] strb;    // Byte enables.
   } axil_w_t;

   // Read data beat, ID on its own port.
   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;    // Read word.
      logic [1:0]             resp;    // Always OKAY.
   } axil_r_t;

   // Single IOb request. A zero strobe marks a read.
   typedef struct packed {
      logic                   valid;   // Request present.
      logic [AXIL_ADDR_W-1:0] addr;    // Byte address.
      logic [AXIL_DATA_W-1:0] wdata;   // Write word.
      logic [AXIL_STRB_W-1:0] wstrb;   // Byte enables.
   } iob_req_t;

   // IOb response back to the master.
   typedef struct packed {
      logic                   ready;   // Request taken this cycle.
      logic                   rvalid;  // Read data strobe.
      logic [AXIL_DATA_W-1:0] rdata;   // Read word.
   } iob_rsp_t;

endpackage

// File: sources.f
axil_pkg.sv
alu_pkg.sv
axil2iob.sv
alu_reg_decode.sv
alu_execute.sv
alu_read_result.sv
axil_alu_top.sv
tb_axil_alu.sv

// File: tb_axil_alu.sv
`timescale 1ns/1ps

module tb_axil_alu
   import axil_pkg::*;
   import alu_pkg::*;
();

   localparam int ID_W     = 2;                      // Wider than default, passed down.
   localparam int HALF_T   = 50;                     // 100 ns clock.
   localparam int N_RAND   = 24;                     // Operand write/readback pairs.
   localparam int N_UNMAP  = 5;                      // RESULT, STATUS and three holes.
   localparam int N_CONC   = 6;                      // Write and read presented together.
   localparam int POLL_EST = 4;                      // STATUS polls per opcode, generous.
   localparam int N_TXN    = 5 + 2*N_RAND + 8*(6 + POLL_EST) + 7*N_UNMAP + 2*N_CONC;

   logic            clk;
   logic            arst_n;
   axil_aw_t        aw;
   logic [ID_W-1:0] awid;
   logic            awvalid, awready;
   axil_w_t         w;
   logic            wvalid, wready;
   logic [ID_W-1:0] bid;
   logic [1:0]      bresp;
   logic            bvalid, bready;
   logic [31:0]     araddr;
   logic [ID_W-1:0] arid;
   logic            arvalid, arready;
   axil_r_t         r;
   logic [ID_W-1:0] rid;
   logic            rvalid, rready;

   logic [31:0]     sh_opa, sh_opb, sh_result;     // Shadow register map.
   alu_op_e         sh_op;
   logic            sh_done;
   logic [ID_W-1:0] exp_bid_q[$];                  // Expected B IDs in order.
   logic            exp_rchk_q[$];                 // Zero for STATUS polls.
   logic [31:0]     exp_rval_q[$];
   logic [ID_W-1:0] exp_rid_q[$];
   int              b_issued, b_seen, r_issued, r_seen;
   logic [31:0]     r_last;                        // Last R data taken.

   axil_alu_top #(
      .AXIL_ID_W(ID_W)
   ) dut0 (
      .clk_i(clk), .arst_n_i(arst_n),
      .axil_aw_i(aw), .axil_awid_i(awid), .axil_awvalid_i(awvalid), .axil_awready_o(awready),
      .axil_w_i(w), .axil_wvalid_i(wvalid), .axil_wready_o(wready),
      .axil_bid_o(bid), .axil_bresp_o(bresp), .axil_bvalid_o(bvalid), .axil_bready_i(bready),
      .axil_araddr_i(araddr), .axil_arid_i(arid), .axil_arvalid_i(arvalid),
      .axil_arready_o(arready),
      .axil_r_o(r), .axil_rid_o(rid), .axil_rvalid_o(rvalid), .axil_rready_i(rready)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_T clk = ~clk;
   end

   function automatic logic [31:0] ref_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
      logic [63:0] prod;
      prod = {32'b0, a} * {32'b0, b};               // Full product, low word kept.
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SHL:  return a << b[4:0];
         OP_SHR:  return a >> b[4:0];
         OP_MUL:  return prod[31:0];
         default: return 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] strobe_merge(logic [31:0] old_v, logic [31:0] new_v,
                                                logic [3:0] strb);
      logic [31:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_v & ~mask) | (new_v & mask);
   endfunction

   function automatic logic [31:0] reg_addr(logic [4:0] off);
      return {27'b0, off};
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped.");
   endtask

   task automatic check_rdata(input axil_r_t got, input logic [ID_W-1:0] got_id,
                              input logic [31:0] exp, input logic [ID_W-1:0] exp_id);
      if (got.data !== exp || got.resp !== AXIL_RESP_OKAY || got_id !== exp_id) begin
         report_fail($sformatf("[ERROR] t=%0t R data %08h resp %0d id %0d, expected %08h id %0d",
                               $time, got.data, got.resp, got_id, exp, exp_id));
      end
   endtask

   task automatic check_bresp(input logic [1:0] resp, input logic [ID_W-1:0] got_id,
                              input logic [ID_W-1:0] exp_id);
      if (resp !== AXIL_RESP_OKAY || got_id !== exp_id) begin
         report_fail($sformatf("[ERROR] t=%0t B resp %0d id %0d, expected OKAY id %0d",
                               $time, resp, got_id, exp_id));
      end
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [ID_W-1:0] id;
      id = ID_W'($urandom);
      exp_bid_q.push_back(id);
      b_issued++;
      aw      <= '{addr: addr};
      awid    <= id;
      awvalid <= 1'b1;
      w       <= '{data: data, strb: strb};
      wvalid  <= 1'b1;
      @(posedge clk);
      while (!awready) @(posedge clk);               // Held until taken.
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr, input logic chk, input logic [31:0] exp,
                           output logic [31:0] data);
      logic [ID_W-1:0] id;
      id = ID_W'($urandom);
      exp_rchk_q.push_back(chk);
      exp_rval_q.push_back(exp);
      exp_rid_q.push_back(id);
      r_issued++;
      araddr  <= addr;
      arid    <= id;
      arvalid <= 1'b1;
      @(posedge clk);
      while (!arready) @(posedge clk);
      arvalid <= 1'b0;
      while (r_seen != r_issued) @(posedge clk);    // Compare process takes the R beat.
      data = r_last;
   endtask

   // AW/W and AR raised in the same cycle, the read must be taken after the write.
   task automatic write_then_read(input logic [31:0] addr, input logic [31:0] data,
                                  input logic [3:0] strb, input logic [31:0] exp);
      logic [ID_W-1:0] wid;
      logic [ID_W-1:0] rdid;
      logic            aw_done;
      logic            ar_done;
      wid  = ID_W'($urandom);
      rdid = ID_W'($urandom);
      exp_bid_q.push_back(wid);
      exp_rchk_q.push_back(1'b1);
      exp_rval_q.push_back(exp);
      exp_rid_q.push_back(rdid);
      b_issued++;
      r_issued++;
      aw      <= '{addr: addr};
      awid    <= wid;
      awvalid <= 1'b1;
      w       <= '{data: data, strb: strb};
      wvalid  <= 1'b1;
      araddr  <= addr;
      arid    <= rdid;
      arvalid <= 1'b1;
      aw_done = 1'b0;
      ar_done = 1'b0;
      while (!(aw_done && ar_done)) begin
         @(posedge clk);
         if (arready) begin
            if (!aw_done) begin
               report_fail("Read was accepted before the write presented in the same cycle.");
            end
            arvalid <= 1'b0;
            ar_done = 1'b1;
         end
         if (awready) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            aw_done = 1'b1;
         end
      end
      while (r_seen != r_issued) @(posedge clk);
   endtask

   task automatic check_map();
      logic [31:0] rd;
      axi_read(reg_addr(OFF_OPA), 1'b1, sh_opa, rd);
      axi_read(reg_addr(OFF_OPB), 1'b1, sh_opb, rd);
      axi_read(reg_addr(OFF_CTRL), 1'b1, {29'b0, sh_op}, rd);
      axi_read(reg_addr(OFF_RESULT), 1'b1, sh_result, rd);
      axi_read(reg_addr(OFF_STATUS), 1'b1, {31'b0, sh_done}, rd);
   endtask

   // Takes B and R beats under random stalls and checks them in order.
   initial begin : compare_proc
      logic            b_hold;
      logic            r_hold;
      logic [ID_W-1:0] b_hold_id;
      logic [ID_W-1:0] r_hold_id;
      axil_r_t         r_hold_v;
      logic            chk;
      logic [31:0]     ev;
      logic [ID_W-1:0] eid;
      b_hold = 1'b0;
      r_hold = 1'b0;
      bready <= 1'b0;
      rready <= 1'b0;
      forever begin
         @(posedge clk);
         if (awready !== wready) begin
            report_fail("AW ready and W ready did not pulse together.");
         end
         if (b_hold && (!bvalid || bid !== b_hold_id)) begin
            report_fail("B response was dropped or changed while bready was low.");
         end
         if (r_hold && (!rvalid || r !== r_hold_v || rid !== r_hold_id)) begin
            report_fail("R response was dropped or changed while rready was low.");
         end
         if (bvalid && bready) begin
            if (exp_bid_q.size() == 0) begin
               report_fail("B response arrived with no write outstanding.");
            end
            eid = exp_bid_q.pop_front();
            check_bresp(bresp, bid, eid);
            b_seen++;
         end
         if (rvalid && rready) begin
            if (exp_rchk_q.size() == 0) begin
               report_fail("R response arrived with no read outstanding.");
            end
            chk = exp_rchk_q.pop_front();
            ev  = exp_rval_q.pop_front();
            eid = exp_rid_q.pop_front();
            if (chk) begin
               check_rdata(r, rid, ev, eid);
            end
            r_last = r.data;
            r_seen++;
         end
         b_hold    = bvalid && !bready;
         b_hold_id = bid;
         r_hold    = rvalid && !rready;
         r_hold_id = rid;
         r_hold_v  = r;
         if (arst_n) begin
            bready <= ($urandom % 3) != 0;           // Stall about a third of cycles.
            rready <= ($urandom % 3) != 0;
         end
      end
   end

   initial begin : watchdog
      repeat (200 * N_TXN) @(posedge clk);
      report_fail($sformatf("Watchdog expired after %0d cycles, the DUT stopped responding.",
                            200 * N_TXN));
   end

   initial begin : main_seq
      logic [31:0] rd;
      logic [31:0] data;
      logic [3:0]  strb;
      logic        sel_b;
      logic [4:0]  off;
      alu_op_e     op;
      void'($urandom(32'hfdc4e963));
      arst_n  <= 1'b0;
      aw      <= '0;
      awid    <= '0;
      awvalid <= 1'b0;
      w       <= '0;
      wvalid  <= 1'b0;
      araddr  <= '0;
      arid    <= '0;
      arvalid <= 1'b0;
      sh_opa = '0;
      sh_opb = '0;
      sh_result = '0;
      sh_op = OP_ADD;
      sh_done = 1'b0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      check_map();                                   // All zero after reset.
      for (int i = 0; i < N_RAND; i++) begin
         sel_b = 1'($urandom);
         data  = $urandom;
         strb  = 4'($urandom);
         if (strb == 4'h0) begin
            strb = 4'h1;                             // Zero strobe would be a read.
         end
         if (sel_b) begin
            sh_opb = strobe_merge(sh_opb, data, strb);
            axi_write(reg_addr(OFF_OPB), data, strb);
            axi_read(reg_addr(OFF_OPB), 1'b1, sh_opb, rd);
         end else begin
            sh_opa = strobe_merge(sh_opa, data, strb);
            axi_write(reg_addr(OFF_OPA), data, strb);
            axi_read(reg_addr(OFF_OPA), 1'b1, sh_opa, rd);
         end
      end
      for (int k = 0; k < 8; k++) begin
         op     = alu_op_e'(k);
         sh_opa = $urandom;
         sh_opb = $urandom;
         axi_write(reg_addr(OFF_OPA), sh_opa, 4'hf);
         axi_write(reg_addr(OFF_OPB), sh_opb, 4'hf);
         axi_write(reg_addr(OFF_CTRL), {29'b0, op}, 4'hf);
         sh_op     = op;
         sh_result = ref_alu(op, sh_opa, sh_opb);
         sh_done   = 1'b1;
         rd = 32'h0;
         while (rd[0] !== 1'b1) begin
            axi_read(reg_addr(OFF_STATUS), 1'b0, 32'h0, rd);   // Poll until done.
         end
         axi_read(reg_addr(OFF_STATUS), 1'b1, 32'h1, rd);
         axi_read(reg_addr(OFF_RESULT), 1'b1, sh_result, rd);
         axi_read(reg_addr(OFF_CTRL), 1'b1, {29'b0, sh_op}, rd);
      end
      for (int u = 0; u < N_UNMAP; u++) begin
         off = OFF_RESULT + 5'(4 * u);               // Read-only regs, then holes.
         axi_write(reg_addr(off), $urandom, 4'hf);
         check_map();
         if (off > OFF_STATUS) begin
            axi_read(reg_addr(off), 1'b1, 32'h0, rd);
         end
      end
      for (int c = 0; c < N_CONC; c++) begin
         data = $urandom;
         strb = 4'($urandom) | 4'h1;
         if (c % 2 == 1) begin
            sh_opb = strobe_merge(sh_opb, data, strb);
            write_then_read(reg_addr(OFF_OPB), data, strb, sh_opb);
         end else begin
            sh_opa = strobe_merge(sh_opa, data, strb);
            write_then_read(reg_addr(OFF_OPA), data, strb, sh_opa);
         end
      end
      while (b_seen != b_issued) @(posedge clk);     // Drain stalled B responses.
      repeat (20) @(posedge clk);                    // Room for a stray duplicate.
      if (b_seen == b_issued && r_seen == r_issued &&
          exp_bid_q.size() == 0 && exp_rchk_q.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         report_fail($sformatf("Response count mismatch: B %0d of %0d, R %0d of %0d.",
                               b_seen, b_issued, r_seen, r_issued));
      end
   end

endmodule
